// ==== source/blur_pkg.sv ====
`default_nettype none

package blur_pkg;

  // image geometry, scaled down
  localparam int PIX_W      = 8;
  localparam int STRIP_PIX  = 4;
  localparam int NUM_STRIPS = 4;
  localparam int IMG_ROWS   = 8;

  // halo of the widest kernel (5x5) on each side
  localparam int HALO    = 2;
  localparam int WIN_PIX = STRIP_PIX + 2 * HALO;

  // idle cycles after a strip's last issue, lets the pipe empty
  localparam int DRAIN_CYCLES = 4;

  typedef logic [PIX_W-1:0] pixel_t;

  // pixel 0 is the leftmost window pixel
  typedef pixel_t [WIN_PIX-1:0] win_row_t;

  // 3x3 payload, one halo pixel per side
  typedef pixel_t [2:0][STRIP_PIX+1:0] win3_t;

  // row 2 is the centre row
  typedef win_row_t [4:0] win5_t;

  typedef pixel_t [STRIP_PIX-1:0] strip_t;

  // strip 0 sits in the low bits of the row word
  typedef strip_t [NUM_STRIPS-1:0] row_word_t;

  typedef logic [$clog2(IMG_ROWS)-1:0]   row_t;
  typedef logic [$clog2(NUM_STRIPS)-1:0] col_t;

endpackage

`default_nettype wire

// ==== source/blur_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module blur_seq (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               start,
  output logic              img_rd,
  output blur_pkg::row_t    img_addr,
  output blur_pkg::col_t    cur_col,
  output logic              issue_valid,
  output logic              blur_rd,
  output blur_pkg::row_t    blur_addr_r,
  output blur_pkg::row_t    wb_row,
  output logic              done
);

  localparam int DRAIN_W = $clog2(blur_pkg::DRAIN_CYCLES);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ISSUE,
    S_DRAIN
  } state_t;

  state_t               state;
  logic [DRAIN_W-1:0]   drain_cnt;
  blur_pkg::row_t       addr_q;
  logic                 last_row;
  logic                 last_col;
  logic                 drain_end;

  assign img_rd    = (state == S_ISSUE);
  assign last_row  = (img_addr == blur_pkg::row_t'(blur_pkg::IMG_ROWS - 1));
  assign last_col  = (cur_col == blur_pkg::col_t'(blur_pkg::NUM_STRIPS - 1));
  assign drain_end = (drain_cnt == DRAIN_W'(blur_pkg::DRAIN_CYCLES - 1));

  // img_addr doubles as the row counter, wraps to 0 for the next strip
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      img_addr  <= '0;
      cur_col   <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          // start is only looked at here
          if (start) begin
            state    <= S_ISSUE;
            img_addr <= '0;
            cur_col  <= '0;
          end
        end
        S_ISSUE: begin
          img_addr <= img_addr + 1'b1;
          if (last_row) begin
            state     <= S_DRAIN;
            drain_cnt <= '0;
          end
        end
        S_DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_end) begin
            if (last_col) begin
              // last write lands this cycle
              state   <= S_IDLE;
              cur_col <= '0;
              done    <= 1'b1;
            end else begin
              state   <= S_ISSUE;
              cur_col <= cur_col + 1'b1;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // strobes follow the row through the pipe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
      blur_rd     <= 1'b0;
    end else begin
      issue_valid <= img_rd;
      blur_rd     <= issue_valid;
    end
  end

  // row tag, t+1 / t+2 / t+3
  always_ff @(posedge clk) begin
    addr_q      <= img_addr;
    blur_addr_r <= addr_q;
    wb_row      <= blur_addr_r;
  end

endmodule

`default_nettype wire

// ==== source/gauss_conv.sv ====
`timescale 1ns/1ps
`default_nettype none

module gauss_conv #(
  parameter int  K     = 3,
  parameter type win_t = blur_pkg::win3_t
) (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               in_valid,
  input  wire win_t         win,
  output logic              out_valid,
  output blur_pkg::strip_t  result
);

  // window columns seen by this kernel
  localparam int W     = blur_pkg::STRIP_PIX + K - 1;
  // weights of one pass sum to 2^(K-1)
  localparam int VS_W  = blur_pkg::PIX_W + K - 1;
  localparam int HS_W  = blur_pkg::PIX_W + 2 * (K - 1);
  localparam int SHIFT = 2 * (K - 1);

  logic [VS_W-1:0]    vsum_d [W];
  logic [VS_W-1:0]    vsum_q [W];
  logic               mid_valid;
  blur_pkg::strip_t   res_d;

  // binomial coefficient, row n of pascal's triangle
  function automatic int binom(input int n, input int k);
    int c;
    c = 1;
    for (int i = 0; i < k; i++) begin
      c = c * (n - i) / (i + 1);
    end
    return c;
  endfunction

  // vertical pass, one sum per window column
  always_comb begin
    for (int c = 0; c < W; c++) begin
      vsum_d[c] = '0;
      for (int r = 0; r < K; r++) begin
        vsum_d[c] = vsum_d[c] + VS_W'(binom(K - 1, r)) * VS_W'(win[r][c]);
      end
    end
  end

  // horizontal pass, output i spans columns i to i+K-1
  always_comb begin
    logic [HS_W-1:0] hsum;
    for (int i = 0; i < blur_pkg::STRIP_PIX; i++) begin
      hsum = '0;
      for (int j = 0; j < K; j++) begin
        hsum = hsum + HS_W'(binom(K - 1, j)) * HS_W'(vsum_q[i + j]);
      end
      res_d[i] = blur_pkg::pixel_t'(hsum >> SHIFT);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_valid <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      mid_valid <= in_valid;
      out_valid <= mid_valid;
    end
  end

  // data advances with its valid, two rows may be in flight
  always_ff @(posedge clk) begin
    if (in_valid) begin
      vsum_q <= vsum_d;
    end
    if (mid_valid) begin
      result <= res_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/strip_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module strip_merge (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       valid3,
  input  wire blur_pkg::strip_t     result3,
  input  wire                       valid5,
  input  wire blur_pkg::strip_t     result5,
  input  wire blur_pkg::row_t       wb_row,
  input  wire blur_pkg::col_t       cur_col,
  input  wire blur_pkg::row_word_t  blur_dout3,
  input  wire blur_pkg::row_word_t  blur_dout5,
  output blur_pkg::row_word_t       blur_din3,
  output blur_pkg::row_word_t       blur_din5,
  output logic                      blur_we3,
  output logic                      blur_we5,
  output blur_pkg::row_t            blur_addr_w
);

  // swap one strip into a read-back row word
  function automatic blur_pkg::row_word_t place_strip(
    input blur_pkg::row_word_t word,
    input blur_pkg::strip_t    strip,
    input blur_pkg::col_t      col
  );
    blur_pkg::row_word_t w;
    w      = word;
    w[col] = strip;
    return w;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_we3 <= 1'b0;
      blur_we5 <= 1'b0;
    end else begin
      blur_we3 <= valid3;
      blur_we5 <= valid5;
    end
  end

  // other strips of the row pass through untouched
  always_ff @(posedge clk) begin
    blur_din3   <= place_strip(blur_dout3, result3, cur_col);
    blur_din5   <= place_strip(blur_dout5, result5, cur_col);
    blur_addr_w <= wb_row;
  end

endmodule

`default_nettype wire

// ==== source/gauss_blur_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gauss_blur_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       start,
  input  wire blur_pkg::win5_t      win,
  input  wire blur_pkg::row_word_t  blur_dout3,
  input  wire blur_pkg::row_word_t  blur_dout5,
  output logic                      done,
  output logic                      img_rd,
  output blur_pkg::row_t            img_addr,
  output blur_pkg::col_t            cur_col,
  output logic                      blur_rd,
  output blur_pkg::row_t            blur_addr_r,
  output blur_pkg::row_word_t       blur_din3,
  output blur_pkg::row_word_t       blur_din5,
  output logic                      blur_we3,
  output logic                      blur_we5,
  output blur_pkg::row_t            blur_addr_w
);

  logic               issue_valid;
  blur_pkg::row_t     wb_row;
  blur_pkg::win3_t    win3;
  logic               valid3;
  logic               valid5;
  blur_pkg::strip_t   result3;
  blur_pkg::strip_t   result5;

  // centre three rows, outer halo pixel dropped on each side
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < blur_pkg::STRIP_PIX + 2; c++) begin
        win3[r][c] = win[r + 1][c + 1];
      end
    end
  end

  blur_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .img_rd      (img_rd),
    .img_addr    (img_addr),
    .cur_col     (cur_col),
    .issue_valid (issue_valid),
    .blur_rd     (blur_rd),
    .blur_addr_r (blur_addr_r),
    .wb_row      (wb_row),
    .done        (done)
  );

  gauss_conv #(
    .K     (3),
    .win_t (blur_pkg::win3_t)
  ) u_conv3 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (issue_valid),
    .win       (win3),
    .out_valid (valid3),
    .result    (result3)
  );

  gauss_conv #(
    .K     (5),
    .win_t (blur_pkg::win5_t)
  ) u_conv5 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (issue_valid),
    .win       (win),
    .out_valid (valid5),
    .result    (result5)
  );

  // both engines line up with the memory read data at t+3
  strip_merge u_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid3      (valid3),
    .result3     (result3),
    .valid5      (valid5),
    .result5     (result5),
    .wb_row      (wb_row),
    .cur_col     (cur_col),
    .blur_dout3  (blur_dout3),
    .blur_dout5  (blur_dout5),
    .blur_din3   (blur_din3),
    .blur_din5   (blur_din5),
    .blur_we3    (blur_we3),
    .blur_we5    (blur_we5),
    .blur_addr_w (blur_addr_w)
  );

endmodule

`default_nettype wire

// ==== test/gauss_blur_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module gauss_blur_chk (
  input wire                  clk,
  input wire                  rst_n,
  input wire                  done,
  input wire                  img_rd,
  input wire                  blur_rd,
  input wire blur_pkg::row_t  blur_addr_r,
  input wire                  blur_we3,
  input wire                  blur_we5,
  input wire blur_pkg::row_t  blur_addr_w
);

  int fail_cnt = 0;

  // all strobes quiet coming out of reset
  reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !(done || img_rd || blur_rd || blur_we3 || blur_we5))
    else begin
      $error("strobe active right after reset");
      fail_cnt++;
    end

  // write lands two cycles after the read of the same row
  rd_to_wr: assert property (@(posedge clk) disable iff (!rst_n)
    blur_rd |-> ##2 (blur_we3 && blur_we5 && blur_addr_w == $past(blur_addr_r, 2)))
    else begin
      $error("row write missing or at the wrong row two cycles after its read");
      fail_cnt++;
    end

  wr_has_rd: assert property (@(posedge clk) disable iff (!rst_n)
    (blur_we3 || blur_we5) |-> $past(blur_rd, 2))
    else begin
      $error("row write without a read two cycles before");
      fail_cnt++;
    end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else begin
      $error("done held high for more than one cycle");
      fail_cnt++;
    end

endmodule

bind gauss_blur_top gauss_blur_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .done        (done),
  .img_rd      (img_rd),
  .blur_rd     (blur_rd),
  .blur_addr_r (blur_addr_r),
  .blur_we3    (blur_we3),
  .blur_we5    (blur_we5),
  .blur_addr_w (blur_addr_w)
);

`default_nettype wire

// ==== test/tb_gauss_blur.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gauss_blur;

  localparam int IMG_COLS   = blur_pkg::NUM_STRIPS * blur_pkg::STRIP_PIX;
  localparam int WRITES     = blur_pkg::IMG_ROWS * blur_pkg::NUM_STRIPS;
  localparam int MAX_CYCLES = 3 * 2 * blur_pkg::NUM_STRIPS
                              * (blur_pkg::IMG_ROWS + blur_pkg::DRAIN_CYCLES) + 50;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 start;
  blur_pkg::win5_t      win;
  blur_pkg::row_word_t  blur_dout3;
  blur_pkg::row_word_t  blur_dout5;
  logic                 done;
  logic                 img_rd;
  blur_pkg::row_t       img_addr;
  blur_pkg::col_t       cur_col;
  logic                 blur_rd;
  blur_pkg::row_t       blur_addr_r;
  blur_pkg::row_word_t  blur_din3;
  blur_pkg::row_word_t  blur_din5;
  logic                 blur_we3;
  logic                 blur_we5;
  blur_pkg::row_t       blur_addr_w;

  // image, memory models and expected rows
  blur_pkg::pixel_t     img [blur_pkg::IMG_ROWS][IMG_COLS];
  blur_pkg::row_word_t  mem3 [blur_pkg::IMG_ROWS];
  blur_pkg::row_word_t  mem5 [blur_pkg::IMG_ROWS];
  blur_pkg::row_word_t  exp3 [blur_pkg::IMG_ROWS];
  blur_pkg::row_word_t  exp5 [blur_pkg::IMG_ROWS];
  int                   tap3 [3] = '{1, 2, 1};
  int                   tap5 [5] = '{1, 4, 6, 4, 1};

  integer               seed;
  int                   errors = 0;
  int                   cycle_cnt = 0;
  int                   we3_cnt;
  int                   we5_cnt;
  blur_pkg::row_t       exp_row = '0;
  blur_pkg::col_t       exp_col = '0;
  logic                 lb_hit;
  blur_pkg::row_t       lb_row;
  blur_pkg::col_t       lb_col;
  logic                 rd_hit;
  blur_pkg::row_word_t  rd3_q;
  blur_pkg::row_word_t  rd5_q;

  gauss_blur_top u_dut (.*);

  always #20 clk = ~clk;

  // zero outside the image
  function automatic blur_pkg::pixel_t get_pix(input int r, input int x);
    if (r < 0 || r >= blur_pkg::IMG_ROWS || x < 0 || x >= IMG_COLS) begin
      return '0;
    end
    return img[r][x];
  endfunction

  function automatic blur_pkg::win5_t build_window(input int row, input int col);
    blur_pkg::win5_t w;
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < blur_pkg::WIN_PIX; c++) begin
        w[r][c] = get_pix(row + r - blur_pkg::HALO,
                          col * blur_pkg::STRIP_PIX + c - blur_pkg::HALO);
      end
    end
    return w;
  endfunction

  // full 2d weighted sum, same as vertical then horizontal with no rounding
  function automatic blur_pkg::pixel_t ref_pixel(input int k, input int r, input int x);
    int h;
    int acc;
    int wv;
    int wh;
    h   = k / 2;
    acc = 0;
    for (int dr = -h; dr <= h; dr++) begin
      for (int dx = -h; dx <= h; dx++) begin
        wv  = (k == 3) ? tap3[dr + h] : tap5[dr + h];
        wh  = (k == 3) ? tap3[dx + h] : tap5[dx + h];
        acc = acc + wv * wh * int'(get_pix(r + dr, x + dx));
      end
    end
    return blur_pkg::pixel_t'(acc >> (2 * (k - 1)));
  endfunction

  task automatic new_image();
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      mem3[r] = '0;
      mem5[r] = '0;
      for (int x = 0; x < IMG_COLS; x++) begin
        img[r][x] = blur_pkg::pixel_t'($random(seed));
      end
    end
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      for (int s = 0; s < blur_pkg::NUM_STRIPS; s++) begin
        for (int i = 0; i < blur_pkg::STRIP_PIX; i++) begin
          exp3[r][s][i] = ref_pixel(3, r, s * blur_pkg::STRIP_PIX + i);
          exp5[r][s][i] = ref_pixel(5, r, s * blur_pkg::STRIP_PIX + i);
        end
      end
    end
  endtask

  task automatic check_results(input int run);
    for (int r = 0; r < blur_pkg::IMG_ROWS; r++) begin
      assert (mem3[r] == exp3[r]) else begin
        $display("Error: blur3 run %0d row %0d expected %h actual %h",
                 run, r, exp3[r], mem3[r]);
        errors++;
      end
      assert (mem5[r] == exp5[r]) else begin
        $display("Error: blur5 run %0d row %0d expected %h actual %h",
                 run, r, exp5[r], mem5[r]);
        errors++;
      end
    end
    assert (we3_cnt == WRITES && we5_cnt == WRITES) else begin
      $display("Error: write_count run %0d expected %0d actual %0d / %0d",
               run, WRITES, we3_cnt, we5_cnt);
      errors++;
    end
  endtask

  // line buffer and both blur memories, outputs move 1 ns after the edge
  always begin
    @(posedge clk);
    lb_hit = img_rd;
    lb_row = img_addr;
    lb_col = cur_col;
    rd_hit = blur_rd;
    rd3_q  = mem3[blur_addr_r];
    rd5_q  = mem5[blur_addr_r];
    if (img_rd) begin
      assert (img_addr == exp_row && cur_col == exp_col) else begin
        $display("Error: row_order expected row %0d strip %0d actual row %0d strip %0d",
                 exp_row, exp_col, img_addr, cur_col);
        errors++;
      end
      exp_row = exp_row + 1'b1;
      if (exp_row == '0) begin
        exp_col = exp_col + 1'b1;
      end
    end
    if (blur_we3) begin
      mem3[blur_addr_w] = blur_din3;
      we3_cnt++;
    end
    if (blur_we5) begin
      mem5[blur_addr_w] = blur_din5;
      we5_cnt++;
    end
    #1;
    if (lb_hit) begin
      win = build_window(int'(lb_row), int'(lb_col));
    end
    if (rd_hit) begin
      blur_dout3 = rd3_q;
      blur_dout5 = rd5_q;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: done not seen within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin : main
    int chk_errors;
    seed       = 32'h7145_f1e3;
    rst_n      = 1'b0;
    start      = 1'b0;
    win        = '0;
    blur_dout3 = '0;
    blur_dout5 = '0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    // second run starts from cleared memories and a fresh image
    for (int run = 0; run < 2; run++) begin
      new_image();
      we3_cnt = 0;
      we5_cnt = 0;
      @(posedge clk);
      #1 start = 1'b1;
      @(posedge clk);
      #1 start = 1'b0;
      @(posedge clk);
      while (!done) @(posedge clk);
      check_results(run);
    end
    chk_errors = u_dut.u_chk.fail_cnt;
    $display("errors: %0d testbench, %0d checker", errors, chk_errors);
    if (errors == 0 && chk_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
source/blur_pkg.sv
source/blur_seq.sv
source/gauss_conv.sv
source/strip_merge.sv
source/gauss_blur_top.sv
test/gauss_blur_chk.sv
test/tb_gauss_blur.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the gauss blur testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gauss_blur -f files.f -o sim_gauss_blur > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_gauss_blur +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "*** TEST FAILED ***" >> sim.log
cat sim.log

grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0
